//--- common/x86_consts.svh
`ifndef X86_CONSTS_SVH
`define X86_CONSTS_SVH

// ---------------------------------------------------------------------------
// general registers after reset, in index order
// ---------------------------------------------------------------------------
`define STARTUP_GPR_EAX     32'h0000_0000
`define STARTUP_GPR_ECX     32'h0000_0000
`define STARTUP_GPR_EDX     32'h0000_0543
`define STARTUP_GPR_EBX     32'h0000_0000
`define STARTUP_GPR_ESP     32'h0000_0000
`define STARTUP_GPR_EBP     32'h0000_0000
`define STARTUP_GPR_ESI     32'h0000_0000
`define STARTUP_GPR_EDI     32'h0000_0000

// ---------------------------------------------------------------------------
// segment selectors and cache valid bits after reset
// ---------------------------------------------------------------------------
`define STARTUP_SEL_ES      16'h0000
`define STARTUP_SEL_CS      16'hF000
`define STARTUP_SEL_SS      16'h0000
`define STARTUP_SEL_DS      16'h0000
`define STARTUP_SEL_FS      16'h0000
`define STARTUP_SEL_GS      16'h0000
`define STARTUP_SEL_LDTR    16'h0000
`define STARTUP_SEL_TR      16'h0000
`define STARTUP_SEG_VALID   8'hFF

// descriptor field positions
`define DESC_BIT_P          47
`define DESC_BIT_SEG        44
`define DESC_DPL_LO         45
`define DESC_TYPE_LO        40

// layout: base hi, flags/limit hi, P, DPL, S, type, base mid, base lo, limit lo
// data, present, dpl 0, read/write, accessed
`define DEFAULT_SEG_CACHE   {8'h00, 8'h00, 1'b1, 2'b00, 1'b1, 4'b0011, 8'h00, 16'h0000, 16'hFFFF}
// code at base ffff0000, readable, accessed
`define DEFAULT_CS_CACHE    {8'hFF, 8'h00, 1'b1, 2'b00, 1'b1, 4'b1011, 8'hFF, 16'h0000, 16'hFFFF}
// system, ldt
`define DEFAULT_LDTR_CACHE  {8'h00, 8'h00, 1'b1, 2'b00, 1'b0, 4'd2, 8'h00, 16'h0000, 16'hFFFF}
// system, busy 386 tss
`define DEFAULT_TR_CACHE    {8'h00, 8'h00, 1'b1, 2'b00, 1'b0, 4'd11, 8'h00, 16'h0000, 16'hFFFF}

`endif

//--- common/gpr_pkg.sv
`default_nettype none

package gpr_pkg;

    // -----------------------------------------------------------------------
    // general register write commands
    // -----------------------------------------------------------------------

    // operand size of a register write
    typedef enum logic [1:0] {
        GPR_BYTE  = 2'd0,
        GPR_WORD  = 2'd1,
        GPR_DWORD = 2'd2
    } gpr_size_e;

    // byte writes to idx 4..7 hit bits 15:8 of registers 0..3 (ah, ch, dh, bh)
    typedef struct packed {
        logic [2:0]  idx;
        gpr_size_e   size;
        logic [31:0] data;
    } gpr_wr_t;

    // -----------------------------------------------------------------------
    // register bank
    // -----------------------------------------------------------------------

    // eax, ecx, edx, ebx, esp, ebp, esi, edi
    typedef logic [7:0][31:0] gpr_bank_t;

endpackage

`default_nettype wire

//--- common/seg_pkg.sv
`default_nettype none

package seg_pkg;

    // -----------------------------------------------------------------------
    // segment indices and operations
    // -----------------------------------------------------------------------

    typedef enum logic [2:0] {
        SEG_ES   = 3'd0,
        SEG_CS   = 3'd1,
        SEG_SS   = 3'd2,
        SEG_DS   = 3'd3,
        SEG_FS   = 3'd4,
        SEG_GS   = 3'd5,
        SEG_LDTR = 3'd6,
        SEG_TR   = 3'd7
    } seg_idx_e;

    typedef enum logic [1:0] {
        SEG_OP_LOAD_SEL    = 2'd0,
        SEG_OP_WRITE_CACHE = 2'd1,
        SEG_OP_SET_VALID   = 2'd2,
        SEG_OP_VALIDATE    = 2'd3
    } seg_op_e;

    // one command; fields unused by the op are don't care
    typedef struct packed {
        seg_op_e     op;
        seg_idx_e    idx;
        logic [15:0] sel;
        logic [1:0]  rpl;
        logic [63:0] desc;
        logic [63:0] mask;
        logic        valid;
    } seg_wr_t;

    // -----------------------------------------------------------------------
    // segment banks, entry n belongs to seg_idx_e value n
    // -----------------------------------------------------------------------
    typedef logic [7:0][15:0] sel_bank_t;
    typedef logic [7:0][1:0]  rpl_bank_t;
    typedef logic [7:0][63:0] cache_bank_t;
    typedef logic [7:0]       valid_bank_t;

endpackage

`default_nettype wire

//--- hdl/cmd_capture.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_capture #(
    parameter type payload_t = logic
) (
    input  wire logic clk,
    input  wire logic rst_n,

    // four-phase request side
    input  wire logic req,
    input  payload_t  payload,
    output logic      ack,

    // toward the register file
    output logic      wr_en,
    output payload_t  wr_cmd
);

    // new command only while ack is low
    logic accept;

    assign accept = req && !ack;

    // -----------------------------------------------------------------------
    // handshake state
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= accept;
            if (accept) begin
                ack <= 1'b1;
            end else if (!req) begin
                // release once the requester has dropped req
                ack <= 1'b0;
            end
        end
    end

    // payload holding register
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_cmd <= payload;
        end
    end

endmodule

`default_nettype wire

//--- hdl/gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "x86_consts.svh"

module gpr_file (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  wire logic          wr_en,
    input  gpr_pkg::gpr_wr_t   wr_cmd,

    output gpr_pkg::gpr_bank_t gpr
);

    localparam gpr_pkg::gpr_bank_t STARTUP_BANK = {
        `STARTUP_GPR_EDI,
        `STARTUP_GPR_ESI,
        `STARTUP_GPR_EBP,
        `STARTUP_GPR_ESP,
        `STARTUP_GPR_EBX,
        `STARTUP_GPR_EDX,
        `STARTUP_GPR_ECX,
        `STARTUP_GPR_EAX
    };

    logic [2:0]  tgt_idx;
    logic [31:0] merged;

    // -----------------------------------------------------------------------
    // sized merge into the target register
    // -----------------------------------------------------------------------
    always_comb begin
        // byte regs 4..7 alias the second byte of regs 0..3
        if (wr_cmd.size == gpr_pkg::GPR_BYTE) begin
            tgt_idx = {1'b0, wr_cmd.idx[1:0]};
        end else begin
            tgt_idx = wr_cmd.idx;
        end

        merged = gpr[tgt_idx];
        case (wr_cmd.size)
            gpr_pkg::GPR_BYTE: begin
                if (wr_cmd.idx[2]) begin
                    merged[15:8] = wr_cmd.data[7:0];
                end else begin
                    merged[7:0] = wr_cmd.data[7:0];
                end
            end
            gpr_pkg::GPR_WORD: begin
                merged[15:0] = wr_cmd.data[15:0];
            end
            gpr_pkg::GPR_DWORD: begin
                merged = wr_cmd.data;
            end
            default: begin
                // unused size code, register kept as is
                merged = gpr[tgt_idx];
            end
        endcase
    end

    // -----------------------------------------------------------------------
    // register bank
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpr <= STARTUP_BANK;
        end else if (wr_en) begin
            gpr[tgt_idx] <= merged;
        end
    end

endmodule

`default_nettype wire

//--- seg/seg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "x86_consts.svh"

module seg_file (
    input  wire logic            clk,
    input  wire logic            rst_n,

    input  wire logic            wr_en,
    input  seg_pkg::seg_wr_t     wr_cmd,

    // mode inputs
    input  wire logic            cr0_pe,
    input  wire logic            vmflag,
    input  wire logic [1:0]      iopl,

    output seg_pkg::sel_bank_t   sel,
    output seg_pkg::rpl_bank_t   rpl,
    output seg_pkg::cache_bank_t cache,
    output seg_pkg::valid_bank_t cache_valid,

    output logic [1:0]           cpl,
    output logic                 protected_mode,
    output logic                 v8086_mode,
    output logic                 real_mode,
    output logic                 io_allow_check_needed
);

    localparam seg_pkg::sel_bank_t STARTUP_SEL = {
        `STARTUP_SEL_TR, `STARTUP_SEL_LDTR, `STARTUP_SEL_GS, `STARTUP_SEL_FS,
        `STARTUP_SEL_DS, `STARTUP_SEL_SS, `STARTUP_SEL_CS, `STARTUP_SEL_ES
    };

    localparam seg_pkg::cache_bank_t STARTUP_CACHE = {
        `DEFAULT_TR_CACHE, `DEFAULT_LDTR_CACHE, `DEFAULT_SEG_CACHE, `DEFAULT_SEG_CACHE,
        `DEFAULT_SEG_CACHE, `DEFAULT_SEG_CACHE, `DEFAULT_CS_CACHE, `DEFAULT_SEG_CACHE
    };

    // only these get checked on a privilege drop
    localparam logic [7:0] DATA_SEGS = (8'd1 << seg_pkg::SEG_ES) | (8'd1 << seg_pkg::SEG_DS) |
                                       (8'd1 << seg_pkg::SEG_FS) | (8'd1 << seg_pkg::SEG_GS);

    logic [63:0] cache_next;
    logic        cache_we;
    logic [7:0]  drop;

    // true when the new cpl may no longer use this segment
    function automatic logic seg_dropped(input logic [63:0] desc, input logic valid,
                                         input logic [1:0] cur_cpl);
        logic [1:0] dpl;
        logic [3:0] kind;
        logic       is_seg;
        logic       is_data;
        logic       is_nc_code;
        dpl        = desc[`DESC_DPL_LO +: 2];
        kind       = desc[`DESC_TYPE_LO +: 4];
        is_seg     = desc[`DESC_BIT_SEG];
        is_data    = is_seg && !kind[3];
        is_nc_code = is_seg && kind[3] && !kind[2];
        return (dpl < cur_cpl) && (!valid || !is_seg || is_data || is_nc_code);
    endfunction

    // -----------------------------------------------------------------------
    // mode and privilege
    // -----------------------------------------------------------------------
    assign cpl                   = rpl[seg_pkg::SEG_CS];
    assign protected_mode        = cr0_pe && !vmflag;
    assign v8086_mode            = cr0_pe && vmflag;
    assign real_mode             = !cr0_pe;
    assign io_allow_check_needed = cr0_pe && (vmflag || (cpl > iopl));

    // -----------------------------------------------------------------------
    // cache merge and validation
    // -----------------------------------------------------------------------
    assign cache_next = (cache[wr_cmd.idx] & wr_cmd.mask) | wr_cmd.desc;
    // ldtr only takes a present descriptor
    assign cache_we   = (wr_cmd.idx != seg_pkg::SEG_LDTR) || wr_cmd.desc[`DESC_BIT_P];

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            drop[i] = DATA_SEGS[i] && seg_dropped(cache[i], cache_valid[i], cpl);
        end
    end

    // -----------------------------------------------------------------------
    // segment state
    // -----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel         <= STARTUP_SEL;
            rpl         <= '0;
            cache       <= STARTUP_CACHE;
            cache_valid <= `STARTUP_SEG_VALID;
        end else if (wr_en) begin
            case (wr_cmd.op)
                seg_pkg::SEG_OP_LOAD_SEL: begin
                    sel[wr_cmd.idx] <= wr_cmd.sel;
                    rpl[wr_cmd.idx] <= wr_cmd.rpl;
                end
                seg_pkg::SEG_OP_WRITE_CACHE: begin
                    if (cache_we) begin
                        cache[wr_cmd.idx] <= cache_next;
                    end
                end
                seg_pkg::SEG_OP_SET_VALID: begin
                    cache_valid[wr_cmd.idx] <= wr_cmd.valid;
                end
                seg_pkg::SEG_OP_VALIDATE: begin
                    for (int i = 0; i < 8; i++) begin
                        if (drop[i]) begin
                            sel[i]         <= '0;
                            cache_valid[i] <= 1'b0;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/regwrite_top.sv
`timescale 1ns/1ps
`default_nettype none

module regwrite_top (
    input  wire logic            clk,
    input  wire logic            rst_n,

    // general register channel
    input  wire logic            gpr_req,
    input  gpr_pkg::gpr_wr_t     gpr_cmd,
    output logic                 gpr_ack,

    // segment channel
    input  wire logic            seg_req,
    input  seg_pkg::seg_wr_t     seg_cmd,
    output logic                 seg_ack,

    input  wire logic            cr0_pe,
    input  wire logic            vmflag,
    input  wire logic [1:0]      iopl,

    // architectural state
    output gpr_pkg::gpr_bank_t   gpr,
    output seg_pkg::sel_bank_t   sel,
    output seg_pkg::rpl_bank_t   rpl,
    output seg_pkg::cache_bank_t cache,
    output seg_pkg::valid_bank_t cache_valid,
    output logic [1:0]           cpl,
    output logic                 protected_mode,
    output logic                 v8086_mode,
    output logic                 real_mode,
    output logic                 io_allow_check_needed
);

    logic             gpr_wr_en;
    gpr_pkg::gpr_wr_t gpr_wr_cmd;
    logic             seg_wr_en;
    seg_pkg::seg_wr_t seg_wr_cmd;

    // -----------------------------------------------------------------------
    // input capture, one per channel
    // -----------------------------------------------------------------------
    cmd_capture #(.payload_t(gpr_pkg::gpr_wr_t)) u_gpr_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (gpr_req),
        .payload (gpr_cmd),
        .ack     (gpr_ack),
        .wr_en   (gpr_wr_en),
        .wr_cmd  (gpr_wr_cmd)
    );

    cmd_capture #(.payload_t(seg_pkg::seg_wr_t)) u_seg_capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (seg_req),
        .payload (seg_cmd),
        .ack     (seg_ack),
        .wr_en   (seg_wr_en),
        .wr_cmd  (seg_wr_cmd)
    );

    // -----------------------------------------------------------------------
    // register files
    // -----------------------------------------------------------------------
    gpr_file u_gpr_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (gpr_wr_en),
        .wr_cmd (gpr_wr_cmd),
        .gpr    (gpr)
    );

    seg_file u_seg_file (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .wr_en                 (seg_wr_en),
        .wr_cmd                (seg_wr_cmd),
        .cr0_pe                (cr0_pe),
        .vmflag                (vmflag),
        .iopl                  (iopl),
        .sel                   (sel),
        .rpl                   (rpl),
        .cache                 (cache),
        .cache_valid           (cache_valid),
        .cpl                   (cpl),
        .protected_mode        (protected_mode),
        .v8086_mode            (v8086_mode),
        .real_mode             (real_mode),
        .io_allow_check_needed (io_allow_check_needed)
    );

endmodule

`default_nettype wire

//--- dv/regwrite_model.svh
`ifndef REGWRITE_MODEL_SVH
`define REGWRITE_MODEL_SVH

// ---------------------------------------------------------------------------
// reference model
// ---------------------------------------------------------------------------

function automatic gpr_pkg::gpr_bank_t merge_gpr(input gpr_pkg::gpr_bank_t bank,
                                                 input gpr_pkg::gpr_wr_t c);
    gpr_pkg::gpr_bank_t result;
    result = bank;
    case (c.size)
        gpr_pkg::GPR_BYTE: begin
            // ah, ch, dh, bh sit in the second byte of regs 0..3
            if (c.idx < 3'd4) begin
                result[c.idx][7:0] = c.data[7:0];
            end else begin
                result[c.idx - 3'd4][15:8] = c.data[7:0];
            end
        end
        gpr_pkg::GPR_WORD: begin
            result[c.idx][15:0] = c.data[15:0];
        end
        gpr_pkg::GPR_DWORD: begin
            result[c.idx] = c.data;
        end
        default: begin
            result = bank;
        end
    endcase
    return result;
endfunction

// present descriptor, base 0, limit ffff
function automatic logic [63:0] make_desc(input logic [1:0] dpl, input logic s,
                                          input logic [3:0] typ);
    return {8'h00, 8'h00, 1'b1, dpl, s, typ, 8'h00, 16'h0000, 16'hFFFF};
endfunction

// only valid conforming code survives a drop below its dpl
function automatic logic seg_unusable(input logic [63:0] desc, input logic valid,
                                      input logic [1:0] cur_cpl);
    logic [1:0] dpl;
    logic [3:0] typ;
    logic       conforming_code;
    dpl             = desc[`DESC_DPL_LO +: 2];
    typ             = desc[`DESC_TYPE_LO +: 4];
    conforming_code = desc[`DESC_BIT_SEG] && typ[3] && typ[2];
    if (dpl >= cur_cpl) begin
        return 1'b0;
    end
    return !valid || !conforming_code;
endfunction

task automatic model_seg(input seg_pkg::seg_wr_t c);
    seg_pkg::seg_idx_e data_segs [4] = '{seg_pkg::SEG_ES, seg_pkg::SEG_DS,
                                         seg_pkg::SEG_FS, seg_pkg::SEG_GS};
    case (c.op)
        seg_pkg::SEG_OP_LOAD_SEL: begin
            exp_sel[c.idx] = c.sel;
            exp_rpl[c.idx] = c.rpl;
        end
        seg_pkg::SEG_OP_WRITE_CACHE: begin
            if (c.idx != seg_pkg::SEG_LDTR || c.desc[`DESC_BIT_P]) begin
                exp_cache[c.idx] = (exp_cache[c.idx] & c.mask) | c.desc;
            end
        end
        seg_pkg::SEG_OP_SET_VALID: begin
            exp_valid[c.idx] = c.valid;
        end
        default: begin
            foreach (data_segs[k]) begin
                if (seg_unusable(exp_cache[data_segs[k]], exp_valid[data_segs[k]],
                                 exp_rpl[seg_pkg::SEG_CS])) begin
                    exp_sel[data_segs[k]]   = '0;
                    exp_valid[data_segs[k]] = 1'b0;
                end
            end
        end
    endcase
endtask

// ---------------------------------------------------------------------------
// four-phase command drivers
// ---------------------------------------------------------------------------

task automatic wait_ack(input logic on_seg, input logic level);
    int cycles;
    cycles = 0;
    while (((on_seg ? seg_ack : gpr_ack) !== level) && cycles < ACK_TIMEOUT) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if ((on_seg ? seg_ack : gpr_ack) !== level) begin
        report_failure($sformatf("timed out waiting for the %s ack to go %s",
                                 on_seg ? "segment" : "gpr", level ? "high" : "low"));
    end
endtask

task automatic send_gpr(input gpr_pkg::gpr_wr_t c);
    gpr_cmd = c;
    gpr_req = 1'b1;
    wait_ack(1'b0, 1'b1);
    gpr_req = 1'b0;
    wait_ack(1'b0, 1'b0);
endtask

task automatic send_seg(input seg_pkg::seg_wr_t c);
    seg_cmd = c;
    seg_req = 1'b1;
    wait_ack(1'b1, 1'b1);
    seg_req = 1'b0;
    wait_ack(1'b1, 1'b0);
endtask

`endif

//--- dv/tb_regwrite.sv
`timescale 1ns/1ps
`default_nettype none

`include "x86_consts.svh"

module tb_regwrite;

    localparam int ACK_TIMEOUT = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 gpr_req;
    gpr_pkg::gpr_wr_t     gpr_cmd;
    logic                 gpr_ack;
    logic                 seg_req;
    seg_pkg::seg_wr_t     seg_cmd;
    logic                 seg_ack;
    logic                 cr0_pe;
    logic                 vmflag;
    logic [1:0]           iopl;
    gpr_pkg::gpr_bank_t   gpr;
    seg_pkg::sel_bank_t   sel;
    seg_pkg::rpl_bank_t   rpl;
    seg_pkg::cache_bank_t cache;
    seg_pkg::valid_bank_t cache_valid;
    logic [1:0]           cpl;
    logic                 protected_mode;
    logic                 v8086_mode;
    logic                 real_mode;
    logic                 io_allow_check_needed;

    // expected architectural state
    gpr_pkg::gpr_bank_t   exp_gpr;
    seg_pkg::sel_bank_t   exp_sel;
    seg_pkg::rpl_bank_t   exp_rpl;
    seg_pkg::cache_bank_t exp_cache;
    seg_pkg::valid_bank_t exp_valid;

    regwrite_top u_regwrite_top (.*);

    always #4 clk = ~clk;

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (actual === expected)
            else report_failure($sformatf("ERROR %s expected %h got %h",
                                          name, expected, actual));
    endtask

    `include "regwrite_model.svh"

    // ------------------------------------------------------------------------
    // handshake rules on every edge
    // ------------------------------------------------------------------------
    assert property (@(posedge clk) disable iff (!rst_n) (!gpr_req && !gpr_ack) |=> !gpr_ack)
        else report_failure("gpr ack rose while no request was present");
    assert property (@(posedge clk) disable iff (!rst_n) (gpr_req && gpr_ack) |=> gpr_ack)
        else report_failure("gpr ack dropped while the request was still held");
    assert property (@(posedge clk) disable iff (!rst_n) (!gpr_req && gpr_ack) |=> !gpr_ack)
        else report_failure("gpr ack stayed high after the request dropped");
    assert property (@(posedge clk) disable iff (!rst_n) gpr_ack |=> !u_regwrite_top.gpr_wr_en)
        else report_failure("gpr command accepted while ack was high");
    assert property (@(posedge clk) disable iff (!rst_n) (!seg_req && !seg_ack) |=> !seg_ack)
        else report_failure("segment ack rose while no request was present");
    assert property (@(posedge clk) disable iff (!rst_n) (!seg_req && seg_ack) |=> !seg_ack)
        else report_failure("segment ack stayed high after the request dropped");
    assert property (@(posedge clk) disable iff (!rst_n) seg_ack |=> !u_regwrite_top.seg_wr_en)
        else report_failure("segment command accepted while ack was high");

    task automatic check_state();
        for (int i = 0; i < 8; i++) begin
            compare_value($sformatf("gpr[%0d]", i), 64'(exp_gpr[i]), 64'(gpr[i]));
            compare_value($sformatf("sel[%0d]", i), 64'(exp_sel[i]), 64'(sel[i]));
            compare_value($sformatf("rpl[%0d]", i), 64'(exp_rpl[i]), 64'(rpl[i]));
            compare_value($sformatf("cache[%0d]", i), exp_cache[i], cache[i]);
            compare_value($sformatf("cache_valid[%0d]", i), 64'(exp_valid[i]),
                          64'(cache_valid[i]));
        end
    endtask

    task automatic write_gpr(input gpr_pkg::gpr_wr_t c);
        send_gpr(c);
        exp_gpr = merge_gpr(exp_gpr, c);
        check_state();
    endtask

    task automatic write_segment(input seg_pkg::seg_wr_t c);
        send_seg(c);
        model_seg(c);
        check_state();
    endtask

    task automatic load_selector(input seg_pkg::seg_idx_e idx, input logic [15:0] s,
                                 input logic [1:0] r);
        seg_pkg::seg_wr_t c;
        c     = '0;
        c.op  = seg_pkg::SEG_OP_LOAD_SEL;
        c.idx = idx;
        c.sel = s;
        c.rpl = r;
        write_segment(c);
    endtask

    task automatic write_cache(input seg_pkg::seg_idx_e idx, input logic [63:0] desc,
                               input logic [63:0] mask);
        seg_pkg::seg_wr_t c;
        c      = '0;
        c.op   = seg_pkg::SEG_OP_WRITE_CACHE;
        c.idx  = idx;
        c.desc = desc;
        c.mask = mask;
        write_segment(c);
    endtask

    task automatic set_valid(input seg_pkg::seg_idx_e idx, input logic v);
        seg_pkg::seg_wr_t c;
        c       = '0;
        c.op    = seg_pkg::SEG_OP_SET_VALID;
        c.idx   = idx;
        c.valid = v;
        write_segment(c);
    endtask

    task automatic validate_segments();
        seg_pkg::seg_wr_t c;
        c    = '0;
        c.op = seg_pkg::SEG_OP_VALIDATE;
        write_segment(c);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        gpr_pkg::gpr_wr_t  gc;
        gpr_pkg::gpr_wr_t  held;
        seg_pkg::seg_idx_e si;
        logic [63:0]       d;
        logic [63:0]       ldtr_before;
        logic              pe;
        logic              vm;
        logic [1:0]        io;
        int                hold;

        void'($urandom(32'h7a7d));
        clk     = 1'b0;
        rst_n   = 1'b0;
        gpr_req = 1'b0;
        gpr_cmd = '0;
        seg_req = 1'b0;
        seg_cmd = '0;
        cr0_pe  = 1'b0;
        vmflag  = 1'b0;
        iopl    = 2'd0;

        exp_gpr   = {`STARTUP_GPR_EDI, `STARTUP_GPR_ESI, `STARTUP_GPR_EBP, `STARTUP_GPR_ESP,
                     `STARTUP_GPR_EBX, `STARTUP_GPR_EDX, `STARTUP_GPR_ECX, `STARTUP_GPR_EAX};
        exp_sel   = {`STARTUP_SEL_TR, `STARTUP_SEL_LDTR, `STARTUP_SEL_GS, `STARTUP_SEL_FS,
                     `STARTUP_SEL_DS, `STARTUP_SEL_SS, `STARTUP_SEL_CS, `STARTUP_SEL_ES};
        exp_cache = {`DEFAULT_TR_CACHE, `DEFAULT_LDTR_CACHE, `DEFAULT_SEG_CACHE,
                     `DEFAULT_SEG_CACHE, `DEFAULT_SEG_CACHE, `DEFAULT_SEG_CACHE,
                     `DEFAULT_CS_CACHE, `DEFAULT_SEG_CACHE};
        exp_rpl   = '0;
        exp_valid = `STARTUP_SEG_VALID;

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // startup values
        check_state();
        compare_value("gpr_ack", 64'd0, 64'(gpr_ack));
        compare_value("seg_ack", 64'd0, 64'(seg_ack));

        repeat (200) begin
            gc.idx  = 3'($urandom_range(0, 7));
            gc.size = gpr_pkg::gpr_size_e'(2'($urandom_range(0, 2)));
            gc.data = $urandom;
            write_gpr(gc);
        end

        // next command waits on the bus while req stays high
        gc.idx    = 3'($urandom_range(0, 7));
        gc.size   = gpr_pkg::GPR_DWORD;
        gc.data   = $urandom;
        held      = gc;
        held.data = ~gc.data;
        gpr_cmd   = gc;
        gpr_req   = 1'b1;
        wait_ack(1'b0, 1'b1);
        gpr_cmd = held;
        hold    = $urandom_range(2, 12);
        repeat (hold) begin
            @(posedge clk);
            #1;
            compare_value("gpr_ack", 64'd1, 64'(gpr_ack));
        end
        exp_gpr = merge_gpr(exp_gpr, gc);
        check_state();
        gpr_req = 1'b0;
        wait_ack(1'b0, 1'b0);
        check_state();
        write_gpr(held);

        // cs rpl sets cpl and the mode outputs follow pe, vm and iopl
        for (int r = 0; r < 4; r++) begin
            pe     = 1'($urandom_range(0, 1));
            vm     = 1'($urandom_range(0, 1));
            io     = 2'($urandom_range(0, 3));
            cr0_pe = pe;
            vmflag = vm;
            iopl   = io;
            load_selector(seg_pkg::SEG_CS, 16'($urandom), 2'(r));
            compare_value("cpl", 64'(r), 64'(cpl));
            compare_value("protected_mode", 64'(pe && !vm), 64'(protected_mode));
            compare_value("v8086_mode", 64'(pe && vm), 64'(v8086_mode));
            compare_value("real_mode", 64'(!pe), 64'(real_mode));
            compare_value("io_allow_check_needed", 64'(pe && (vm || 2'(r) > io)),
                          64'(io_allow_check_needed));
        end
        for (int i = 0; i < 8; i++) begin
            if (i != seg_pkg::SEG_CS) begin
                load_selector(seg_pkg::seg_idx_e'(3'(i)), 16'($urandom),
                              2'($urandom_range(0, 3)));
            end
        end

        // masked cache writes and valid bits
        repeat (40) begin
            si = seg_pkg::seg_idx_e'(3'($urandom_range(0, 7)));
            write_cache(si, {$urandom, $urandom}, {$urandom, $urandom});
        end
        ldtr_before        = exp_cache[seg_pkg::SEG_LDTR];
        d                  = {$urandom, $urandom};
        d[`DESC_BIT_P]     = 1'b0;
        write_cache(seg_pkg::SEG_LDTR, d, 64'd0);
        compare_value("cache[ldtr]", ldtr_before, cache[seg_pkg::SEG_LDTR]);
        repeat (16) begin
            si = seg_pkg::seg_idx_e'(3'($urandom_range(0, 7)));
            set_valid(si, 1'($urandom_range(0, 1)));
        end

        // privilege drop to 3 with dpl 0 data in ds and fs
        load_selector(seg_pkg::SEG_CS, 16'h001B, 2'd3);
        load_selector(seg_pkg::SEG_DS, 16'h0010, 2'd0);
        load_selector(seg_pkg::SEG_FS, 16'h0018, 2'd0);
        load_selector(seg_pkg::SEG_ES, 16'h0023, 2'd3);
        load_selector(seg_pkg::SEG_GS, 16'h0028, 2'd0);
        write_cache(seg_pkg::SEG_DS, make_desc(2'd0, 1'b1, 4'b0011), 64'd0);
        write_cache(seg_pkg::SEG_FS, make_desc(2'd0, 1'b1, 4'b0001), 64'd0);
        // dpl 3 data and conforming code stay usable
        write_cache(seg_pkg::SEG_ES, make_desc(2'd3, 1'b1, 4'b0011), 64'd0);
        write_cache(seg_pkg::SEG_GS, make_desc(2'd0, 1'b1, 4'b1110), 64'd0);
        // dpl 0 ss and cs lie outside the data segment check
        write_cache(seg_pkg::SEG_SS, make_desc(2'd0, 1'b1, 4'b0011), 64'd0);
        write_cache(seg_pkg::SEG_CS, make_desc(2'd0, 1'b1, 4'b1010), 64'd0);
        set_valid(seg_pkg::SEG_SS, 1'b1);
        set_valid(seg_pkg::SEG_CS, 1'b1);
        set_valid(seg_pkg::SEG_ES, 1'b1);
        set_valid(seg_pkg::SEG_DS, 1'b1);
        set_valid(seg_pkg::SEG_FS, 1'b1);
        set_valid(seg_pkg::SEG_GS, 1'b1);
        validate_segments();
        compare_value("sel[ds]", 64'd0, 64'(sel[seg_pkg::SEG_DS]));
        compare_value("sel[fs]", 64'd0, 64'(sel[seg_pkg::SEG_FS]));
        compare_value("cache_valid[ds]", 64'd0, 64'(cache_valid[seg_pkg::SEG_DS]));
        compare_value("cache_valid[fs]", 64'd0, 64'(cache_valid[seg_pkg::SEG_FS]));
        compare_value("sel[es]", 64'h0023, 64'(sel[seg_pkg::SEG_ES]));
        compare_value("sel[gs]", 64'h0028, 64'(sel[seg_pkg::SEG_GS]));
        compare_value("cache_valid[gs]", 64'd1, 64'(cache_valid[seg_pkg::SEG_GS]));

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
+incdir+dv
common/gpr_pkg.sv
common/seg_pkg.sv
hdl/cmd_capture.sv
hdl/gpr_file.sv
seg/seg_file.sv
hdl/regwrite_top.sv
dv/tb_regwrite.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_regwrite
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
